//--- jesd_ctl_pkg.sv
// Shared lane/transceiver status types and default sizes, imported by all control-plane RTL
package jesd_ctl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Default sizes
    //////////////////////////////////////////////////////////////////////

    // Receive lanes whose status can be read back
    localparam int NUM_LANES_DEF = 4;

    // Receive buffer fill level width
    localparam int USEDW_W = 10;

    // Link error counter width
    localparam int ERR_W = 32;

    // Channel select width, 1-based channel numbers
    localparam int CHAN_W = 4;

    // Reset sequencer counter width
    localparam int SEQ_CNT_W = 32;

    //////////////////////////////////////////////////////////////////////
    // Lane status
    //////////////////////////////////////////////////////////////////////

    // One lane as seen by the host, 42 bits
    typedef struct packed {
        logic [USEDW_W-1:0] usedw;
        logic [ERR_W-1:0]   err_link;
    } lane_status_t;

    // All readable lanes, lane 0 in the low bits
    typedef lane_status_t [NUM_LANES_DEF-1:0] lane_status_arr_t;

    //////////////////////////////////////////////////////////////////////
    // Transceiver control and status
    //////////////////////////////////////////////////////////////////////

    // Reported by the transceiver
    typedef struct packed {
        logic tx_reset_done;
        logic rx_reset_done;
        logic powergood;
    } gt_status_t;

    // Driven towards the transceiver, plus the
    // sequence completion flag for the link reset logic
    typedef struct packed {
        logic sys_reset;
        logic data_reset;
        logic seq_done;
    } gt_reset_t;

endpackage

//--- gt_reset_sequencer.sv
// Transceiver reset sequencer: timed system and data reset windows counted from power good
module gt_reset_sequencer #(
    parameter int unsigned SYS_START  = 20,
    parameter int unsigned SYS_LEN    = 10,
    parameter int unsigned DATA_START = 50,
    parameter int unsigned DATA_LEN   = 10
) (
    input  logic                   rst_ctl_clk,
    input  logic                   pll_locked,
    input  logic                   powergood_i,
    output jesd_ctl_pkg::gt_reset_t gt_reset_o
);

    import jesd_ctl_pkg::*;

    // Window bounds, both ends inclusive
    localparam logic [SEQ_CNT_W-1:0] SYS_FIRST  = SEQ_CNT_W'(SYS_START);
    localparam logic [SEQ_CNT_W-1:0] SYS_LAST   = SEQ_CNT_W'(SYS_START + SYS_LEN);
    localparam logic [SEQ_CNT_W-1:0] DATA_FIRST = SEQ_CNT_W'(DATA_START);
    localparam logic [SEQ_CNT_W-1:0] DATA_LAST  = SEQ_CNT_W'(DATA_START + DATA_LEN);

    // Done is reported one cycle after the data reset has dropped
    localparam logic [SEQ_CNT_W-1:0] DONE_AT    = SEQ_CNT_W'(DATA_START + DATA_LEN + 2);

    logic [SEQ_CNT_W-1:0] seq_cnt;

    //////////////////////////////////////////////////////////////////////
    // Sequence counter
    //////////////////////////////////////////////////////////////////////

    // Restarts on every loss of power good, holds at all ones
    always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
        if (!pll_locked) begin
            seq_cnt <= '0;
        end else if (!powergood_i) begin
            seq_cnt <= '0;
        end else if (!(&seq_cnt)) begin
            seq_cnt <= seq_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reset windows
    //////////////////////////////////////////////////////////////////////

    // DATA_START is expected past SYS_START + SYS_LEN,
    // so the two windows never overlap
    always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
        if (!pll_locked) begin
            gt_reset_o <= '0;
        end else begin
            gt_reset_o.sys_reset  <= powergood_i &&
                                     (seq_cnt >= SYS_FIRST) && (seq_cnt <= SYS_LAST);
            gt_reset_o.data_reset <= powergood_i &&
                                     (seq_cnt >= DATA_FIRST) && (seq_cnt <= DATA_LAST);
            gt_reset_o.seq_done   <= powergood_i && (seq_cnt >= DONE_AT);
        end
    end

endmodule

//--- link_reset_ctl.sv
// Link reset control: releases the active-low link reset once the transceiver is fully up
module link_reset_ctl (
    input  logic                     rst_ctl_clk,
    input  logic                     pll_locked,
    input  jesd_ctl_pkg::gt_status_t gt_status_i,
    input  jesd_ctl_pkg::gt_reset_t  gt_reset_i,
    output logic                     link_reset_b_o
);

    import jesd_ctl_pkg::*;

    logic       link_qual;
    logic [1:0] link_sync_q;

    //////////////////////////////////////////////////////////////////////
    // Qualification
    //////////////////////////////////////////////////////////////////////

    // Both directions reset done, power good and the sequencer finished
    always_comb begin
        link_qual = gt_status_i.tx_reset_done &
                    gt_status_i.rx_reset_done &
                    gt_status_i.powergood     &
                    gt_reset_i.seq_done;
    end

    //////////////////////////////////////////////////////////////////////
    // Two-stage synchronizer
    //////////////////////////////////////////////////////////////////////

    // Done flags come from transceiver clock domains
    always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
        if (!pll_locked) begin
            link_sync_q <= '0;
        end else begin
            link_sync_q <= {link_sync_q[0], link_qual};
        end
    end

    // Follows the qualified state both ways, two cycles late
    assign link_reset_b_o = link_sync_q[1];

endmodule

//--- phy_ready_qualifier.sv
// Link-up qualifier: raises the software readiness flag after a full saturating count
module phy_ready_qualifier #(
    parameter int unsigned READY_CNT_W = 6
) (
    input  logic rst_ctl_clk,
    input  logic pll_locked,
    input  logic link_up_i,
    output logic phy_ready_o
);

    logic [READY_CNT_W-1:0] up_cnt;

    //////////////////////////////////////////////////////////////////////
    // Link-up time counter
    //////////////////////////////////////////////////////////////////////

    // Any drop of the link restarts the count
    always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
        if (!pll_locked) begin
            up_cnt <= '0;
        end else if (!link_up_i) begin
            up_cnt <= '0;
        end else if (!(&up_cnt)) begin
            up_cnt <= up_cnt + 1'b1;
        end
    end

    // Saturated count means the link stayed up long enough,
    // short glitches never reach software
    always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
        if (!pll_locked) begin
            phy_ready_o <= 1'b0;
        end else begin
            phy_ready_o <= link_up_i & (&up_cnt);
        end
    end

endmodule

//--- lane_status_readback.sv
// Lane status read port: four-phase req/ack returning the status of one selected channel
module lane_status_readback #(
    parameter int unsigned NUM_LANES = jesd_ctl_pkg::NUM_LANES_DEF
) (
    input  logic                                 rst_ctl_clk,
    input  logic                                 pll_locked,
    input  jesd_ctl_pkg::lane_status_arr_t       lane_status_i,
    input  logic [jesd_ctl_pkg::CHAN_W-1:0]      rd_channel_i,
    input  logic                                 rd_req_i,
    output logic                                 rd_ack_o,
    output jesd_ctl_pkg::lane_status_t           rd_data_o
);

    import jesd_ctl_pkg::*;

    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_ACK  = 1'b1
    } rd_state_t;

    rd_state_t    rd_state;
    rd_state_t    rd_state_nxt;
    lane_status_t sel_status;

    //////////////////////////////////////////////////////////////////////
    // Channel select
    //////////////////////////////////////////////////////////////////////

    // Channel n maps to lane n-1, channel 0 and anything
    // above NUM_LANES read as zeros
    always_comb begin
        sel_status = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (rd_channel_i == CHAN_W'(i + 1)) begin
                sel_status = lane_status_i[i];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            RD_IDLE: begin
                if (rd_req_i) begin
                    rd_state_nxt = RD_ACK;
                end
            end
            RD_ACK: begin
                // Host releases req to close the transfer
                if (!rd_req_i) begin
                    rd_state_nxt = RD_IDLE;
                end
            end
            default: begin
                rd_state_nxt = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
        if (!pll_locked) begin
            rd_state <= RD_IDLE;
        end else begin
            rd_state <= rd_state_nxt;
        end
    end

    assign rd_ack_o = (rd_state == RD_ACK);

    // Captured on entry to ack, then held until the next request
    always_ff @(posedge rst_ctl_clk) begin
        if (rd_state == RD_IDLE && rd_req_i) begin
            rd_data_o <= sel_status;
        end
    end

endmodule

//--- link_sync.sv
// Link synchronization: SYSREF and DAC SYNC~ synchronizers, SYSREF edge pulse, combined ADC SYNC~
module link_sync #(
    parameter int unsigned NUM_LANES = jesd_ctl_pkg::NUM_LANES_DEF
) (
    input  logic                 rst_ctl_clk,
    input  logic                 pll_locked,
    input  logic                 sysref_i,
    input  logic                 dac_sync_b_i,
    input  logic [NUM_LANES-1:0] adc_sync_b_lanes_i,
    output logic                 sysref_edge_o,
    output logic                 sync_b_o,
    output logic                 adc_sync_b_o,
    output logic                 comma_align_en_o
);

    logic [2:0]           sysref_q;
    logic [1:0]           dac_sync_q;
    logic [NUM_LANES-1:0] adc_lanes_q;

    //////////////////////////////////////////////////////////////////////
    // SYSREF and DAC SYNC~
    //////////////////////////////////////////////////////////////////////

    // Two sync stages, the third stage only serves the edge detector
    always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
        if (!pll_locked) begin
            sysref_q      <= '0;
            sysref_edge_o <= 1'b0;
            dac_sync_q    <= '0;
        end else begin
            sysref_q      <= {sysref_q[1:0], sysref_i};
            sysref_edge_o <= sysref_q[1] & ~sysref_q[2];
            dac_sync_q    <= {dac_sync_q[0], dac_sync_b_i};
        end
    end

    assign sync_b_o = dac_sync_q[1];

    //////////////////////////////////////////////////////////////////////
    // ADC SYNC~
    //////////////////////////////////////////////////////////////////////

    // Any lane asking for sync pulls the combined SYNC~ low,
    // which turns comma alignment on
    always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
        if (!pll_locked) begin
            adc_lanes_q      <= '0;
            adc_sync_b_o     <= 1'b0;
            comma_align_en_o <= 1'b1;
        end else begin
            adc_lanes_q      <= adc_sync_b_lanes_i;
            adc_sync_b_o     <= &adc_lanes_q;
            comma_align_en_o <= ~(&adc_lanes_q);
        end
    end

endmodule

//--- jesd_ctl_top.sv
// JESD204B control plane top: reset sequencing, link reset, readiness, status readback, sync
module jesd_ctl_top #(
    parameter int unsigned SYS_START   = 20,
    parameter int unsigned SYS_LEN     = 10,
    parameter int unsigned DATA_START  = 50,
    parameter int unsigned DATA_LEN    = 10,
    parameter int unsigned READY_CNT_W = 6,
    parameter int unsigned NUM_LANES   = 4
) (
    input  logic                             rst_ctl_clk,
    input  logic                             pll_locked,
    // Transceiver
    input  jesd_ctl_pkg::gt_status_t         gt_status_i,
    output jesd_ctl_pkg::gt_reset_t          gt_reset_o,
    // Link status
    input  jesd_ctl_pkg::lane_status_arr_t   lane_status_i,
    output logic                             link_reset_b_o,
    output logic                             phy_ready_o,
    // Host readback
    input  logic [jesd_ctl_pkg::CHAN_W-1:0]  rd_channel_i,
    input  logic                             rd_req_i,
    output logic                             rd_ack_o,
    output jesd_ctl_pkg::lane_status_t       rd_data_o,
    // JESD204B sync
    input  logic                             sysref_i,
    input  logic                             dac_sync_b_i,
    input  logic [NUM_LANES-1:0]             adc_sync_b_lanes_i,
    output logic                             sysref_edge_o,
    output logic                             sync_b_o,
    output logic                             adc_sync_b_o,
    output logic                             comma_align_en_o
);

    import jesd_ctl_pkg::*;

    gt_reset_t gt_reset;
    logic      link_reset_b;

    //////////////////////////////////////////////////////////////////////
    // Reset chain
    //////////////////////////////////////////////////////////////////////

    gt_reset_sequencer #(
        .SYS_START  (SYS_START),
        .SYS_LEN    (SYS_LEN),
        .DATA_START (DATA_START),
        .DATA_LEN   (DATA_LEN)
    ) gt_reset_sequencer_inst (
        .rst_ctl_clk (rst_ctl_clk),
        .pll_locked  (pll_locked),
        .powergood_i (gt_status_i.powergood),
        .gt_reset_o  (gt_reset)
    );

    link_reset_ctl link_reset_ctl_inst (
        .rst_ctl_clk    (rst_ctl_clk),
        .pll_locked     (pll_locked),
        .gt_status_i    (gt_status_i),
        .gt_reset_i     (gt_reset),
        .link_reset_b_o (link_reset_b)
    );

    // Link reset doubles as the link-up indication
    phy_ready_qualifier #(
        .READY_CNT_W (READY_CNT_W)
    ) phy_ready_qualifier_inst (
        .rst_ctl_clk (rst_ctl_clk),
        .pll_locked  (pll_locked),
        .link_up_i   (link_reset_b),
        .phy_ready_o (phy_ready_o)
    );

    assign gt_reset_o     = gt_reset;
    assign link_reset_b_o = link_reset_b;

    //////////////////////////////////////////////////////////////////////
    // Host readback and sync
    //////////////////////////////////////////////////////////////////////

    lane_status_readback #(
        .NUM_LANES (NUM_LANES)
    ) lane_status_readback_inst (
        .rst_ctl_clk   (rst_ctl_clk),
        .pll_locked    (pll_locked),
        .lane_status_i (lane_status_i),
        .rd_channel_i  (rd_channel_i),
        .rd_req_i      (rd_req_i),
        .rd_ack_o      (rd_ack_o),
        .rd_data_o     (rd_data_o)
    );

    link_sync #(
        .NUM_LANES (NUM_LANES)
    ) link_sync_inst (
        .rst_ctl_clk        (rst_ctl_clk),
        .pll_locked         (pll_locked),
        .sysref_i           (sysref_i),
        .dac_sync_b_i       (dac_sync_b_i),
        .adc_sync_b_lanes_i (adc_sync_b_lanes_i),
        .sysref_edge_o      (sysref_edge_o),
        .sync_b_o           (sync_b_o),
        .adc_sync_b_o       (adc_sync_b_o),
        .comma_align_en_o   (comma_align_en_o)
    );

endmodule

//--- tb_jesd_ctl_tasks.svh
// Directed tests and compare tasks for the control-plane testbench, included in its module body
`ifndef TB_JESD_CTL_TASKS_SVH
`define TB_JESD_CTL_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Helpers and compare tasks
//////////////////////////////////////////////////////////////////////

// Inputs change 1 ns after the rising edge
task automatic next_cycle();
    @(posedge rst_ctl_clk);
    #1;
endtask

task automatic sysref_cycle();
    next_cycle();
    if (sysref_edge_o) edge_cnt++;
endtask

task automatic report_failure(input string msg);
    error_cnt++;
    $display("%0d ns: %s", $time, msg);
endtask

task automatic end_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, error_cnt - errors_before);
endtask

task automatic check_bit(input string name, input logic got, input logic expected);
    check_cnt++;
    if (got !== expected) begin
        error_cnt++;
        $display("error at %0d ns: %s = %b, expected %b", $time, name, got, expected);
    end
endtask

task automatic check_gt_reset(input string name, input gt_reset_t got,
                              input gt_reset_t expected);
    check_cnt++;
    if (got !== expected) begin
        error_cnt++;
        $display("error at %0d ns: %s = %b, expected %b", $time, name, got, expected);
    end
endtask

task automatic check_status(input string name, input lane_status_t got,
                            input lane_status_t expected);
    check_cnt++;
    if (got !== expected) begin
        error_cnt++;
        $display("error at %0d ns: %s = %h, expected %h", $time, name, got, expected);
    end
endtask

task automatic check_count(input string name, input int got, input int expected);
    check_cnt++;
    if (got != expected) begin
        error_cnt++;
        $display("error at %0d ns: %s = %0d, expected %0d", $time, name, got, expected);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Reset state and transceiver reset sequence
//////////////////////////////////////////////////////////////////////

task automatic test_reset_state();
    int start;
    start = error_cnt;
    check_gt_reset("gt_reset_o", gt_reset_o, '0);
    check_bit("link_reset_b_o", link_reset_b_o, 1'b0);
    check_bit("phy_ready_o", phy_ready_o, 1'b0);
    check_bit("rd_ack_o", rd_ack_o, 1'b0);
    check_bit("sysref_edge_o", sysref_edge_o, 1'b0);
    check_bit("adc_sync_b_o", adc_sync_b_o, 1'b0);
    check_bit("comma_align_en_o", comma_align_en_o, 1'b1);
    end_test("reset_state", start);
endtask

// One power-good run, returns once seq_done is seen
task automatic run_sequence();
    gt_reset_t done_state;
    int n;
    int sys_cnt;
    int sys_last;
    int data_cnt;
    int data_first;
    int data_last;
    n = 0;
    sys_cnt = 0;
    sys_last = -1;
    data_cnt = 0;
    data_first = -1;
    data_last = -1;
    done_state = '0;
    done_state.seq_done = 1'b1;
    gt_status_i.powergood = 1'b1;
    while (!gt_reset_o.seq_done) begin
        next_cycle();
        n++;
        if (gt_reset_o.sys_reset) begin
            sys_cnt++;
            sys_last = n;
        end
        if (gt_reset_o.data_reset) begin
            if (data_first < 0) data_first = n;
            data_cnt++;
            data_last = n;
        end
    end
    check_count("gt_reset_o.sys_reset high cycles", sys_cnt, SYS_LEN + 1);
    check_count("gt_reset_o.data_reset high cycles", data_cnt, DATA_LEN + 1);
    check_count("cycles from last data_reset to seq_done", n - data_last, 2);
    if (data_first <= sys_last) report_failure("data_reset started before sys_reset ended");
    check_gt_reset("gt_reset_o", gt_reset_o, done_state);
endtask

task automatic test_reset_sequence();
    int start;
    start = error_cnt;
    repeat (4) begin
        next_cycle();
        check_gt_reset("gt_reset_o", gt_reset_o, '0);
    end
    run_sequence();
    // Losing power good clears everything on the next edge
    gt_status_i.powergood = 1'b0;
    next_cycle();
    check_gt_reset("gt_reset_o", gt_reset_o, '0);
    next_cycle();
    run_sequence();
    end_test("reset_sequence", start);
endtask

//////////////////////////////////////////////////////////////////////
// Link reset and readiness
//////////////////////////////////////////////////////////////////////

task automatic test_link_reset();
    int start;
    int n;
    start = error_cnt;
    gt_status_i.tx_reset_done = 1'b1;
    repeat (4) begin
        next_cycle();
        check_bit("link_reset_b_o", link_reset_b_o, 1'b0);
    end
    gt_status_i.rx_reset_done = 1'b1;
    n = 0;
    while (!link_reset_b_o) begin
        next_cycle();
        n++;
    end
    check_count("cycles to link_reset_b_o rise", n, 2);
    gt_status_i.tx_reset_done = 1'b0;
    n = 0;
    while (link_reset_b_o) begin
        next_cycle();
        n++;
    end
    check_count("cycles to link_reset_b_o fall", n, 2);
    end_test("link_reset", start);
endtask

// Called on the cycle where link_reset_b_o has just risen
task automatic measure_ready();
    int n;
    n = 0;
    check_bit("phy_ready_o", phy_ready_o, 1'b0);
    while (!phy_ready_o) begin
        next_cycle();
        n++;
    end
    // Full count of 2^W - 1 plus the output register
    check_count("cycles from link_reset_b_o rise to phy_ready_o", n,
                (1 << READY_CNT_W) - 1 + 1);
endtask

task automatic test_readiness();
    int start;
    start = error_cnt;
    gt_status_i.tx_reset_done = 1'b1;
    while (!link_reset_b_o) next_cycle();
    measure_ready();
    // One cycle without tx_reset_done drops the link for one cycle
    gt_status_i.tx_reset_done = 1'b0;
    next_cycle();
    gt_status_i.tx_reset_done = 1'b1;
    while (link_reset_b_o) next_cycle();
    while (!link_reset_b_o) next_cycle();
    measure_ready();
    end_test("readiness", start);
endtask

//////////////////////////////////////////////////////////////////////
// Status readback and link sync
//////////////////////////////////////////////////////////////////////

task automatic test_readback();
    lane_status_arr_t lanes;
    lane_status_t     expected;
    int               start;
    int               n;
    start = error_cnt;
    for (int i = 0; i < NUM_LANES; i++) begin
        lanes[i].usedw    = USEDW_W'($urandom);
        lanes[i].err_link = $urandom;
    end
    lane_status_i = lanes;
    for (int c = 0; c < 16; c++) begin
        // Channels are 1-based, everything else reads zeros
        expected = '0;
        if (c >= 1 && c <= NUM_LANES) expected = lanes[(c + NUM_LANES - 1) % NUM_LANES];
        rd_channel_i = CHAN_W'(c);
        next_cycle();
        check_bit("rd_ack_o", rd_ack_o, 1'b0);
        rd_req_i = 1'b1;
        next_cycle();
        check_bit("rd_ack_o", rd_ack_o, 1'b1);
        check_status("rd_data_o", rd_data_o, expected);
        lane_status_i = ~lanes;
        next_cycle();
        check_bit("rd_ack_o", rd_ack_o, 1'b1);
        rd_req_i = 1'b0;
        n = 0;
        while (rd_ack_o && n < 3) begin
            next_cycle();
            n++;
        end
        if (rd_ack_o) report_failure("rd_ack_o stayed high after rd_req_i was released");
        check_status("rd_data_o", rd_data_o, expected);
        lane_status_i = lanes;
    end
    end_test("readback", start);
endtask

task automatic test_sync();
    logic [NUM_LANES-1:0] bits;
    logic                 dac;
    int                   start;
    int                   pulses;
    int                   width;
    int                   gap;
    start = error_cnt;
    for (int k = 0; k < 8; k++) begin
        bits = NUM_LANES'($urandom);
        dac = 1'($urandom);
        // First rounds cover all lanes synced, all lanes requesting sync
        // and both DAC SYNC~ levels
        if (k == 0) begin
            bits = '1;
            dac = 1'b1;
        end
        if (k == 1) begin
            bits = '0;
            dac = 1'b0;
        end
        adc_sync_b_lanes_i = bits;
        dac_sync_b_i = dac;
        repeat (3) next_cycle();
        check_bit("adc_sync_b_o", adc_sync_b_o, &bits);
        check_bit("comma_align_en_o", comma_align_en_o, ~(&bits));
        check_bit("sync_b_o", sync_b_o, dac);
    end
    // SYSREF pulses one to three cycles wide, rising edges at least 4 cycles apart
    edge_cnt = 0;
    pulses = 6;
    for (int p = 0; p < pulses; p++) begin
        width = 1 + p % 3;
        sysref_i = 1'b1;
        repeat (width) sysref_cycle();
        sysref_i = 1'b0;
        gap = 3 + $urandom % 4;
        repeat (gap) sysref_cycle();
    end
    repeat (6) sysref_cycle();
    check_count("sysref_edge_o pulses", edge_cnt, pulses);
    end_test("sync", start);
endtask

`endif

//--- tb_jesd_ctl.sv
// Testbench top for the JESD204B control plane, runs the directed tests on jesd_ctl_top
module tb_jesd_ctl;

    timeunit 1ns;
    timeprecision 100ps;

    import jesd_ctl_pkg::*;

    localparam int SYS_START   = 20;
    localparam int SYS_LEN     = 10;
    localparam int DATA_START  = 50;
    localparam int DATA_LEN    = 10;
    localparam int READY_CNT_W = 6;
    localparam int NUM_LANES   = 4;

    // Rough length of each test in cycles
    localparam int RESET_LEN    = 16 + 4;
    localparam int SEQ_LEN      = 2 * (DATA_START + DATA_LEN + 8);
    localparam int LINK_LEN     = 20;
    localparam int READY_LEN    = 2 * ((1 << READY_CNT_W) + 8);
    localparam int READBACK_LEN = 16 * 8;
    localparam int SYNC_LEN     = 8 * 3 + 6 * 9 + 6;
    localparam int TIMEOUT_CYCLES = RESET_LEN + SEQ_LEN + LINK_LEN + READY_LEN
                                  + READBACK_LEN + SYNC_LEN + 200;

    logic                 rst_ctl_clk;
    logic                 pll_locked;
    gt_status_t           gt_status_i;
    gt_reset_t            gt_reset_o;
    lane_status_arr_t     lane_status_i;
    logic                 link_reset_b_o;
    logic                 phy_ready_o;
    logic [CHAN_W-1:0]    rd_channel_i;
    logic                 rd_req_i;
    logic                 rd_ack_o;
    lane_status_t         rd_data_o;
    logic                 sysref_i;
    logic                 dac_sync_b_i;
    logic [NUM_LANES-1:0] adc_sync_b_lanes_i;
    logic                 sysref_edge_o;
    logic                 sync_b_o;
    logic                 adc_sync_b_o;
    logic                 comma_align_en_o;

    int check_cnt;
    int error_cnt;
    int cycle_cnt;
    int edge_cnt;

    jesd_ctl_top #(
        .SYS_START   (SYS_START),
        .SYS_LEN     (SYS_LEN),
        .DATA_START  (DATA_START),
        .DATA_LEN    (DATA_LEN),
        .READY_CNT_W (READY_CNT_W),
        .NUM_LANES   (NUM_LANES)
    ) jesd_ctl_top_inst (.*);

    `include "tb_jesd_ctl_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // Clock and timeout
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_ctl_clk = 1'b0;
        forever #4 rst_ctl_clk = ~rst_ctl_clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge rst_ctl_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hc949c7ed));
        check_cnt          = 0;
        error_cnt          = 0;
        edge_cnt           = 0;
        pll_locked         = 1'b1;
        gt_status_i        = '0;
        lane_status_i      = '0;
        rd_channel_i       = '0;
        rd_req_i           = 1'b0;
        sysref_i           = 1'b0;
        dac_sync_b_i       = 1'b0;
        adc_sync_b_lanes_i = '0;
        // Real falling edge so the asynchronous reset fires
        #2 pll_locked = 1'b0;
        repeat (16) @(posedge rst_ctl_clk);
        #1;
        test_reset_state();
        pll_locked = 1'b1;
        test_reset_sequence();
        test_link_reset();
        test_readiness();
        test_readback();
        test_sync();
        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
jesd_ctl_pkg.sv
gt_reset_sequencer.sv
link_reset_ctl.sv
phy_ready_qualifier.sv
lane_status_readback.sv
link_sync.sv
jesd_ctl_top.sv
tb_jesd_ctl.sv

//--- run_sim.sh
#!/bin/sh
# Build the control-plane testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_jesd_ctl \
    -f filelist.f -Mdir obj_dir -o tb_jesd_ctl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_jesd_ctl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
